//--- files.f
source/rx_pkg.sv
source/rx_byte_counter.sv
source/rx_field_capture.sv
source/rx_manager.sv
source/rx_fifo.sv
source/rx_wrapper.sv
tb/rx_wrapper_checker.sv
tb/rx_wrapper_tb.sv

//--- source/rx_byte_counter.sv
module rx_byte_counter
(
	input  logic            rx_xcvr_clk,
	input  logic            rst,
	input  logic            valid,
	input  logic            sop,
	input  logic            eop,
	output rx_pkg::offset_t offset
);

	rx_pkg::offset_t count;                       // offset of the next beat

	always_ff @(posedge rx_xcvr_clk)
	begin
		if (rst)
			count <= '0;
		else if (valid)
		begin
			if (eop)
				count <= '0;                      // ready for the next frame
			else if (sop)
				count <= 11'd1;
			else if (count != '1)
				count <= count + 11'd1;           // hold at 2047 on long frames
		end
	end

	// a start beat is always offset 0, whatever the counter holds
	assign offset = (valid && sop) ? '0 : count;

endmodule

//--- source/rx_field_capture.sv
module rx_field_capture
#(
	parameter type field_t = rx_pkg::byte_t,
	parameter int  OFFSET  = 0
)
(
	input  logic            rx_xcvr_clk,
	input  logic            rst,
	input  logic            valid,
	input  rx_pkg::offset_t offset,
	input  rx_pkg::byte_t   data,
	output field_t          field
);

	localparam int field_bits  = $bits(field_t);
	localparam int field_bytes = field_bits / 8;

	localparam rx_pkg::offset_t win_first = rx_pkg::offset_t'(OFFSET);
	localparam rx_pkg::offset_t win_last  = rx_pkg::offset_t'(OFFSET + field_bytes - 1);

	logic                  in_window;
	logic [field_bits+7:0] shifted;               // field with the new byte appended

	always_comb
	begin
		in_window = valid && (offset >= win_first) && (offset <= win_last);
		shifted   = {field, data};
	end

	// network order, so the first byte ends up in the top bits
	always_ff @(posedge rx_xcvr_clk)
	begin
		if (rst)
			field <= '0;
		else if (in_window)
			field <= shifted[field_bits-1:0];
	end

endmodule

//--- source/rx_fifo.sv
module rx_fifo
#(
	parameter type entry_t = logic [7:0],
	parameter int  DEPTH   = 16
)
(
	input  logic   rx_xcvr_clk,
	input  logic   rst,
	input  logic   wr,
	input  entry_t din,
	input  logic   rd,
	output entry_t dout,
	output logic   empty,
	output logic   full
);

	localparam int aw = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int cw = $clog2(DEPTH + 1);
	localparam logic [aw-1:0] ptr_last = aw'(DEPTH - 1);

	entry_t          mem [DEPTH];
	logic [aw-1:0]   wr_ptr;
	logic [aw-1:0]   rd_ptr;
	logic [cw-1:0]   count;
	logic [cw-1:0]   count_next;
	logic            do_wr;
	logic            do_rd;

	assign do_wr = wr && !full;                   // writes into a full buffer are dropped
	assign do_rd = rd && !empty;

	always_comb
		count_next = count + cw'(do_wr) - cw'(do_rd);

	always_ff @(posedge rx_xcvr_clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			empty  <= 1'b1;
			full   <= 1'b0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
			count <= count_next;
			empty <= (count_next == '0);          // flags follow the count one cycle late
			full  <= (count_next == cw'(DEPTH));
		end
	end

	always_ff @(posedge rx_xcvr_clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= din;
		if (do_rd)
			dout <= mem[rd_ptr];                  // held until the next pop
	end

endmodule

//--- source/rx_manager.sv
module rx_manager
(
	input  logic               rx_xcvr_clk,
	input  logic               rst,

	input  rx_pkg::mac_t       local_mac,
	input  rx_pkg::ip_t        local_ip,
	input  rx_pkg::port_t      local_port_0,
	input  rx_pkg::port_t      local_port_1,

	input  logic               st_rx_startofpacket,
	input  logic               st_rx_endofpacket,
	input  logic               st_rx_valid,
	input  rx_pkg::byte_t      st_rx_data,
	input  logic               st_rx_error,

	input  rx_pkg::offset_t    offset,
	input  rx_pkg::mac_t       dst_mac,
	input  rx_pkg::mac_t       src_mac,
	input  rx_pkg::port_t      ethertype,
	input  rx_pkg::byte_t      protocol,
	input  rx_pkg::ip_t        src_ip,
	input  rx_pkg::ip_t        dst_ip,
	input  rx_pkg::port_t      src_port,
	input  rx_pkg::port_t      dst_port,
	input  rx_pkg::port_t      udp_len,

	output logic               data_wr_0,
	output logic               data_wr_1,
	output rx_pkg::byte_t      wr_data,
	output logic               status_wr_0,
	output logic               status_wr_1,
	output rx_pkg::rx_status_t status
);

	typedef enum logic [2:0]
	{
		st_idle,
		st_header,
		st_payload,
		st_discard,
		st_finish
	} state_t;

	state_t        state;
	logic          sel;                           // 1 selects stream 1
	rx_pkg::port_t payload_cnt;

	logic          frame_match;
	logic          beat_sop;
	logic          beat_eop;
	logic          in_payload;
	logic          short_payload;
	rx_pkg::port_t cnt_next;

	always_comb
	begin
		frame_match = ((dst_mac == local_mac) || (dst_mac == rx_pkg::BROADCAST_MAC))
			&& (ethertype == rx_pkg::ETHERTYPE_IPV4)
			&& (protocol == rx_pkg::PROTO_UDP)
			&& (dst_ip == local_ip)
			&& ((dst_port == local_port_0) || (dst_port == local_port_1));

		beat_sop = st_rx_valid && st_rx_startofpacket && !st_rx_endofpacket;
		beat_eop = st_rx_valid && st_rx_endofpacket;

		// udp_len is complete from offset 40, well before the first payload byte
		in_payload = st_rx_valid && (offset >= rx_pkg::OFS_PAYLOAD)
			&& (({1'b0, payload_cnt} + 17'(rx_pkg::UDP_HDR_LEN)) < {1'b0, udp_len});
		cnt_next = payload_cnt + rx_pkg::port_t'(in_payload);

		// frame ended before udp_length said it would
		short_payload = ({1'b0, cnt_next} + 17'(rx_pkg::UDP_HDR_LEN)) < {1'b0, udp_len};
	end

	always_ff @(posedge rx_xcvr_clk)
	begin
		if (rst)
		begin
			state       <= st_idle;
			sel         <= 1'b0;
			payload_cnt <= '0;
			data_wr_0   <= 1'b0;
			data_wr_1   <= 1'b0;
		end
		else
		begin
			data_wr_0 <= 1'b0;
			data_wr_1 <= 1'b0;
			case (state)
				st_idle:
					if (beat_sop)
						state <= st_header;
				st_header:
					if (beat_eop)
						state <= st_idle;                 // runt frame, nothing reported
					else if (st_rx_valid && (offset == rx_pkg::OFS_UDP_LEN))
					begin
						sel         <= (dst_port != local_port_0);
						payload_cnt <= '0;
						state       <= frame_match ? st_payload : st_discard;
					end
				st_payload:
				begin
					if (in_payload)
					begin
						data_wr_0   <= !sel;
						data_wr_1   <= sel;
						payload_cnt <= cnt_next;
					end
					if (beat_eop)
						state <= st_finish;
				end
				st_discard:
					if (beat_eop)
						state <= st_idle;
				st_finish:
					state <= beat_sop ? st_header : st_idle;  // next frame may start here
				default:
					state <= st_idle;
			endcase
		end
	end

	// payload byte and status record trail their beat by one cycle
	always_ff @(posedge rx_xcvr_clk)
	begin
		wr_data <= st_rx_data;
		if ((state == st_payload) && beat_eop)
		begin
			status.src_mac     <= src_mac;
			status.src_ip      <= src_ip;
			status.src_port    <= src_port;
			status.payload_len <= cnt_next;
			status.error       <= st_rx_error || short_payload;
		end
	end

	assign status_wr_0 = (state == st_finish) && !sel;
	assign status_wr_1 = (state == st_finish) && sel;

endmodule

//--- source/rx_pkg.sv
package rx_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [47:0] mac_t;
	typedef logic [31:0] ip_t;
	typedef logic [15:0] port_t;                  // also used for 16-bit header words
	typedef logic [10:0] offset_t;                // beat offset, saturates at 2047

	typedef struct packed
	{
		mac_t  src_mac;
		ip_t   src_ip;
		port_t src_port;
		port_t payload_len;                       // payload bytes actually written
		logic  error;                             // st_rx_error or short payload
	} rx_status_t;

	// byte offsets from the first destination MAC byte
	localparam offset_t OFS_DST_MAC   = 11'd0;
	localparam offset_t OFS_SRC_MAC   = 11'd6;
	localparam offset_t OFS_ETHERTYPE = 11'd12;
	localparam offset_t OFS_PROTOCOL  = 11'd23;
	localparam offset_t OFS_SRC_IP    = 11'd26;
	localparam offset_t OFS_DST_IP    = 11'd30;
	localparam offset_t OFS_SRC_PORT  = 11'd34;
	localparam offset_t OFS_DST_PORT  = 11'd36;
	localparam offset_t OFS_UDP_LEN   = 11'd38;   // also the decision point
	localparam offset_t OFS_PAYLOAD   = 11'd42;

	localparam port_t ETHERTYPE_IPV4 = 16'h0800;
	localparam byte_t PROTO_UDP      = 8'd17;
	localparam port_t UDP_HDR_LEN    = 16'd8;     // udp_length counts the header too
	localparam mac_t  BROADCAST_MAC  = '1;

endpackage

//--- source/rx_wrapper.sv
module rx_wrapper
#(
	parameter int DATA_DEPTH   = 256,
	parameter int STATUS_DEPTH = 8
)
(
	input  logic               rx_xcvr_clk,
	input  logic               rst,

	input  rx_pkg::mac_t       local_mac,
	input  rx_pkg::ip_t        local_ip,
	input  rx_pkg::port_t      local_port_0,
	input  rx_pkg::port_t      local_port_1,

	input  logic               st_rx_startofpacket,
	input  logic               st_rx_endofpacket,
	input  logic               st_rx_valid,
	input  rx_pkg::byte_t      st_rx_data,
	input  logic               st_rx_error,

	input  logic               rdreq_data_0,
	output rx_pkg::byte_t      data_out_0,
	output logic               rdempty_data_0,
	input  logic               rdreq_status_0,
	output rx_pkg::rx_status_t status_out_0,
	output logic               rdempty_status_0,

	input  logic               rdreq_data_1,
	output rx_pkg::byte_t      data_out_1,
	output logic               rdempty_data_1,
	input  logic               rdreq_status_1,
	output rx_pkg::rx_status_t status_out_1,
	output logic               rdempty_status_1
);

	rx_pkg::offset_t    offset;
	rx_pkg::mac_t       dst_mac;
	rx_pkg::mac_t       src_mac;
	rx_pkg::port_t      ethertype;
	rx_pkg::byte_t      protocol;
	rx_pkg::ip_t        src_ip;
	rx_pkg::ip_t        dst_ip;
	rx_pkg::port_t      src_port;
	rx_pkg::port_t      dst_port;
	rx_pkg::port_t      udp_len;

	logic               data_wr_0;
	logic               data_wr_1;
	rx_pkg::byte_t      wr_data;
	logic               status_wr_0;
	logic               status_wr_1;
	rx_pkg::rx_status_t status;

	rx_byte_counter rx_byte_counter_i (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst), .valid(st_rx_valid),
		.sop(st_rx_startofpacket), .eop(st_rx_endofpacket), .offset(offset)
	);

	// header field captures, all fed from the raw stream
	rx_field_capture #(.field_t(rx_pkg::mac_t), .OFFSET(rx_pkg::OFS_DST_MAC)) dst_mac_cap (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst), .valid(st_rx_valid),
		.offset(offset), .data(st_rx_data), .field(dst_mac)
	);
	rx_field_capture #(.field_t(rx_pkg::mac_t), .OFFSET(rx_pkg::OFS_SRC_MAC)) src_mac_cap (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst), .valid(st_rx_valid),
		.offset(offset), .data(st_rx_data), .field(src_mac)
	);
	rx_field_capture #(.field_t(rx_pkg::port_t), .OFFSET(rx_pkg::OFS_ETHERTYPE)) ethertype_cap (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst), .valid(st_rx_valid),
		.offset(offset), .data(st_rx_data), .field(ethertype)
	);
	rx_field_capture #(.field_t(rx_pkg::byte_t), .OFFSET(rx_pkg::OFS_PROTOCOL)) protocol_cap (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst), .valid(st_rx_valid),
		.offset(offset), .data(st_rx_data), .field(protocol)
	);
	rx_field_capture #(.field_t(rx_pkg::ip_t), .OFFSET(rx_pkg::OFS_SRC_IP)) src_ip_cap (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst), .valid(st_rx_valid),
		.offset(offset), .data(st_rx_data), .field(src_ip)
	);
	rx_field_capture #(.field_t(rx_pkg::ip_t), .OFFSET(rx_pkg::OFS_DST_IP)) dst_ip_cap (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst), .valid(st_rx_valid),
		.offset(offset), .data(st_rx_data), .field(dst_ip)
	);
	rx_field_capture #(.field_t(rx_pkg::port_t), .OFFSET(rx_pkg::OFS_SRC_PORT)) src_port_cap (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst), .valid(st_rx_valid),
		.offset(offset), .data(st_rx_data), .field(src_port)
	);
	rx_field_capture #(.field_t(rx_pkg::port_t), .OFFSET(rx_pkg::OFS_DST_PORT)) dst_port_cap (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst), .valid(st_rx_valid),
		.offset(offset), .data(st_rx_data), .field(dst_port)
	);
	rx_field_capture #(.field_t(rx_pkg::port_t), .OFFSET(rx_pkg::OFS_UDP_LEN)) udp_len_cap (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst), .valid(st_rx_valid),
		.offset(offset), .data(st_rx_data), .field(udp_len)
	);

	rx_manager rx_manager_i (
		.rx_xcvr_clk(rx_xcvr_clk),
		.rst(rst),
		.local_mac(local_mac),
		.local_ip(local_ip),
		.local_port_0(local_port_0),
		.local_port_1(local_port_1),
		.st_rx_startofpacket(st_rx_startofpacket),
		.st_rx_endofpacket(st_rx_endofpacket),
		.st_rx_valid(st_rx_valid),
		.st_rx_data(st_rx_data),
		.st_rx_error(st_rx_error),
		.offset(offset),
		.dst_mac(dst_mac),
		.src_mac(src_mac),
		.ethertype(ethertype),
		.protocol(protocol),
		.src_ip(src_ip),
		.dst_ip(dst_ip),
		.src_port(src_port),
		.dst_port(dst_port),
		.udp_len(udp_len),
		.data_wr_0(data_wr_0),
		.data_wr_1(data_wr_1),
		.wr_data(wr_data),
		.status_wr_0(status_wr_0),
		.status_wr_1(status_wr_1),
		.status(status)
	);

	// both streams see the same write data, the strobes pick the FIFO
	rx_fifo #(.entry_t(rx_pkg::byte_t), .DEPTH(DATA_DEPTH)) data_fifo_0 (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst), .wr(data_wr_0), .din(wr_data),
		.rd(rdreq_data_0), .dout(data_out_0), .empty(rdempty_data_0), .full()
	);
	rx_fifo #(.entry_t(rx_pkg::rx_status_t), .DEPTH(STATUS_DEPTH)) status_fifo_0 (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst), .wr(status_wr_0), .din(status),
		.rd(rdreq_status_0), .dout(status_out_0), .empty(rdempty_status_0), .full()
	);
	rx_fifo #(.entry_t(rx_pkg::byte_t), .DEPTH(DATA_DEPTH)) data_fifo_1 (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst), .wr(data_wr_1), .din(wr_data),
		.rd(rdreq_data_1), .dout(data_out_1), .empty(rdempty_data_1), .full()
	);
	rx_fifo #(.entry_t(rx_pkg::rx_status_t), .DEPTH(STATUS_DEPTH)) status_fifo_1 (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst), .wr(status_wr_1), .din(status),
		.rd(rdreq_status_1), .dout(status_out_1), .empty(rdempty_status_1), .full()
	);

endmodule

//--- tb/rx_wrapper_checker.sv
module rx_wrapper_checker
(
	input logic clk,
	input logic rst,
	input logic excl_a,
	input logic excl_b,
	input logic eop_beat,
	input logic status_strobe,
	input logic wr,
	input logic full
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;                           // failed assertions so far

	// only one stream may take a payload byte
	assert property (@(posedge clk) disable iff (rst) !(excl_a && excl_b))
		else
		begin
			fail_count++;
			$error("both data write strobes high");
		end

	assert property (@(posedge clk) disable iff (rst) status_strobe |-> $past(eop_beat))
		else
		begin
			fail_count++;
			$error("status strobe without end of packet one cycle before");
		end

	assert property (@(posedge clk) disable iff (rst) !(wr && full))
		else
		begin
			fail_count++;
			$error("write into a full FIFO");
		end

endmodule

bind rx_manager rx_wrapper_checker mgr_chk (
	.clk(rx_xcvr_clk), .rst(rst), .excl_a(data_wr_0), .excl_b(data_wr_1),
	.eop_beat(st_rx_valid && st_rx_endofpacket), .status_strobe(status_wr_0 || status_wr_1),
	.wr(1'b0), .full(1'b0)
);

bind rx_fifo rx_wrapper_checker fifo_chk (
	.clk(rx_xcvr_clk), .rst(rst), .excl_a(1'b0), .excl_b(1'b0),
	.eop_beat(1'b0), .status_strobe(1'b0), .wr(wr), .full(full)
);

//--- tb/rx_wrapper_tb.sv
module rx_wrapper_tb;

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed
	{
		rx_pkg::mac_t  dst_mac;
		rx_pkg::port_t ethertype;
		rx_pkg::byte_t protocol;
		rx_pkg::ip_t   dst_ip;
		rx_pkg::port_t dst_port;
		logic [15:0]   plen;                      // udp payload bytes
		logic          err;
		logic [3:0]    gap;                       // idle cycles after the frame
		logic [1:0]    exp_stream;                // 2 means dropped
	} frame_row_t;

	localparam rx_pkg::mac_t  my_mac = 48'h02_00_00_00_00_01;
	localparam rx_pkg::ip_t   my_ip  = 32'hc0a8_0101;
	localparam rx_pkg::port_t port_a = 16'd5000;
	localparam rx_pkg::port_t port_b = 16'd6000;

	logic rx_xcvr_clk = 1'b0;
	logic rst;
	logic sop, eop, valid, err_in;
	rx_pkg::byte_t data_in;
	logic rdreq_data_0, rdreq_data_1, rdreq_status_0, rdreq_status_1;
	rx_pkg::byte_t data_out_0, data_out_1;
	rx_pkg::rx_status_t status_out_0, status_out_1;
	logic rdempty_data_0, rdempty_data_1, rdempty_status_0, rdempty_status_1;

	frame_row_t rows[$];
	rx_pkg::byte_t frame[0:127];
	rx_pkg::byte_t exp_data_0[$], exp_data_1[$], got_data_0[$], got_data_1[$];
	rx_pkg::rx_status_t exp_stat_0[$], exp_stat_1[$], got_stat_0[$], got_stat_1[$];
	logic [31:0] lcg_state = 32'h17f2;
	int errors = 0;
	int frame_errs = 0;
	int passed = 0;
	logic timed_out = 1'b0;

	rx_wrapper #(.DATA_DEPTH(256), .STATUS_DEPTH(8)) rx_wrapper_i (
		.rx_xcvr_clk(rx_xcvr_clk), .rst(rst),
		.local_mac(my_mac), .local_ip(my_ip), .local_port_0(port_a), .local_port_1(port_b),
		.st_rx_startofpacket(sop), .st_rx_endofpacket(eop), .st_rx_valid(valid),
		.st_rx_data(data_in), .st_rx_error(err_in),
		.rdreq_data_0(rdreq_data_0), .data_out_0(data_out_0), .rdempty_data_0(rdempty_data_0),
		.rdreq_status_0(rdreq_status_0), .status_out_0(status_out_0),
		.rdempty_status_0(rdempty_status_0),
		.rdreq_data_1(rdreq_data_1), .data_out_1(data_out_1), .rdempty_data_1(rdempty_data_1),
		.rdreq_status_1(rdreq_status_1), .status_out_1(status_out_1),
		.rdempty_status_1(rdempty_status_1)
	);

	always #20 rx_xcvr_clk = !rx_xcvr_clk;

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function frame_row_t make_row(rx_pkg::mac_t mac, rx_pkg::port_t et, rx_pkg::byte_t proto,
		rx_pkg::ip_t ip, rx_pkg::port_t port, int plen, logic err, int gap, int stream);
		frame_row_t r;
		r = '{mac, et, proto, ip, port, 16'(plen), err, 4'(gap), 2'(stream)};
		return r;
	endfunction

	// assertion failures counted by every bound checker instance
	function int assertion_failures();
		return rx_wrapper_i.rx_manager_i.mgr_chk.fail_count
			+ rx_wrapper_i.data_fifo_0.fifo_chk.fail_count
			+ rx_wrapper_i.status_fifo_0.fifo_chk.fail_count
			+ rx_wrapper_i.data_fifo_1.fifo_chk.fail_count
			+ rx_wrapper_i.status_fifo_1.fifo_chk.fail_count;
	endfunction

	task put_field(input int ofs, input int nbytes, input logic [47:0] value);
		for (int i = 0; i < nbytes; i++)
			frame[ofs + i] = value[8 * (nbytes - 1 - i) +: 8];   // network order
	endtask

	task check_byte(input rx_pkg::byte_t got, input rx_pkg::byte_t exp, input string what);
		if (got !== exp)
		begin
			$display("Error %0t: %s got %02h expected %02h", $time, what, got, exp);
			errors++;
			frame_errs++;
		end
	endtask

	task check_status(input rx_pkg::rx_status_t got, input rx_pkg::rx_status_t exp,
		input string what);
		if (got !== exp)
		begin
			$display("Error %0t: %s got %h expected %h", $time, what, got, exp);
			errors++;
			frame_errs++;
		end
	endtask

	task send_frame(input frame_row_t r);
		int len;
		rx_pkg::rx_status_t st;
		len = 42 + r.plen;
		if (len < 60)
			len = 60;                             // ethernet minimum without fcs
		for (int i = 0; i < 128; i++)
			frame[i] = 8'(i) ^ 8'ha5;             // filler under unused header bytes and padding
		st.src_mac = {16'(lcg_next() >> 16), lcg_next()};
		st.src_ip = lcg_next();
		st.src_port = 16'(lcg_next() >> 8);
		st.payload_len = r.plen;
		st.error = r.err;
		put_field(rx_pkg::OFS_DST_MAC, 6, r.dst_mac);
		put_field(rx_pkg::OFS_SRC_MAC, 6, st.src_mac);
		put_field(rx_pkg::OFS_ETHERTYPE, 2, r.ethertype);
		frame[14] = 8'h45;
		put_field(16, 2, 28 + r.plen);            // ip total length
		frame[22] = 8'd64;
		put_field(rx_pkg::OFS_PROTOCOL, 1, r.protocol);
		put_field(rx_pkg::OFS_SRC_IP, 4, st.src_ip);
		put_field(rx_pkg::OFS_DST_IP, 4, r.dst_ip);
		put_field(rx_pkg::OFS_SRC_PORT, 2, st.src_port);
		put_field(rx_pkg::OFS_DST_PORT, 2, r.dst_port);
		put_field(rx_pkg::OFS_UDP_LEN, 2, r.plen + rx_pkg::UDP_HDR_LEN);
		for (int i = 0; i < r.plen; i++)
		begin
			frame[rx_pkg::OFS_PAYLOAD + i] = 8'(lcg_next() >> 16);
			if (r.exp_stream == 0)
				exp_data_0.push_back(frame[rx_pkg::OFS_PAYLOAD + i]);
			else if (r.exp_stream == 1)
				exp_data_1.push_back(frame[rx_pkg::OFS_PAYLOAD + i]);
		end
		if (r.exp_stream == 0)
			exp_stat_0.push_back(st);
		else if (r.exp_stream == 1)
			exp_stat_1.push_back(st);
		for (int i = 0; i < len; i++)
		begin
			@(posedge rx_xcvr_clk);
			#2;
			valid = 1'b1;
			sop = (i == 0);
			eop = (i == len - 1);
			err_in = r.err && (i == len - 1);
			data_in = frame[i];
		end
	endtask

	task idle(input int cycles);
		for (int i = 0; i < cycles; i++)
		begin
			@(posedge rx_xcvr_clk);
			#2;
			valid = 1'b0;
			sop = 1'b0;
			eop = 1'b0;
			err_in = 1'b0;
		end
	endtask

	// pops until empty stays high for a while, bounded by a cycle limit
	task drain(input int which);
		int quiet;
		int cycles;
		logic empty_now;
		quiet = 0;
		cycles = 0;
		while (quiet < 8 && cycles < 1000)
		begin
			@(posedge rx_xcvr_clk);
			#2;
			cycles++;
			empty_now = (which == 0) ? rdempty_data_0 : (which == 1) ? rdempty_data_1 :
				(which == 2) ? rdempty_status_0 : rdempty_status_1;
			if (empty_now)
				quiet++;
			else
			begin
				quiet = 0;
				rdreq_data_0 = (which == 0);
				rdreq_data_1 = (which == 1);
				rdreq_status_0 = (which == 2);
				rdreq_status_1 = (which == 3);
				@(posedge rx_xcvr_clk);
				#2;
				{rdreq_data_0, rdreq_data_1, rdreq_status_0, rdreq_status_1} = 4'b0;
				case (which)
					0: got_data_0.push_back(data_out_0);
					1: got_data_1.push_back(data_out_1);
					2: got_stat_0.push_back(status_out_0);
					default: got_stat_1.push_back(status_out_1);
				endcase
			end
		end
		if (cycles >= 1000)
		begin
			$display("FIFO %0d never stayed empty, drain timed out", which);
			timed_out = 1'b1;
		end
	endtask

	initial
	begin
		rst = 1'b1;
		{sop, eop, valid, err_in} = 4'b0;
		data_in = 8'h00;
		{rdreq_data_0, rdreq_data_1, rdreq_status_0, rdreq_status_1} = 4'b0;
		rows.push_back(make_row(my_mac, 16'h0800, 8'd17, my_ip, port_a, 20, 0, 3, 0));
		rows.push_back(make_row(my_mac, 16'h0800, 8'd17, my_ip, port_b, 30, 0, 3, 1));
		rows.push_back(make_row('1, 16'h0800, 8'd17, my_ip, port_a, 10, 0, 3, 0));
		rows.push_back(make_row(48'h02_00_00_00_00_09, 16'h0800, 8'd17, my_ip, port_a, 12, 0, 2, 2));
		rows.push_back(make_row(my_mac, 16'h0800, 8'd17, 32'hc0a8_0102, port_a, 12, 0, 2, 2));
		rows.push_back(make_row(my_mac, 16'h0806, 8'd17, my_ip, port_a, 12, 0, 2, 2));
		rows.push_back(make_row(my_mac, 16'h0800, 8'd6, my_ip, port_b, 12, 0, 2, 2));
		rows.push_back(make_row(my_mac, 16'h0800, 8'd17, my_ip, 16'd7000, 12, 0, 2, 2));
		rows.push_back(make_row(my_mac, 16'h0800, 8'd17, my_ip, port_b, 12, 1, 3, 1));
		rows.push_back(make_row(my_mac, 16'h0800, 8'd17, my_ip, port_a, 6, 0, 3, 0));
		rows.push_back(make_row(my_mac, 16'h0800, 8'd17, my_ip, port_b, 16, 0, 0, 1));
		rows.push_back(make_row(my_mac, 16'h0800, 8'd17, my_ip, port_a, 16, 0, 0, 0));
		rows.push_back(make_row(my_mac, 16'h0800, 8'd17, my_ip, port_b, 8, 0, 0, 1));
		rows.push_back(make_row(my_mac, 16'h0800, 8'd17, my_ip, port_a, 25, 0, 3, 0));
		repeat (8) @(posedge rx_xcvr_clk);
		#2 rst = 1'b0;
		idle(4);
		foreach (rows[k])
		begin
			send_frame(rows[k]);
			if (rows[k].gap != 0)
				idle(rows[k].gap);
		end
		idle(8);
		for (int f = 0; f < 4; f++)
			if (!timed_out)
				drain(f);
		if (timed_out)
			$display("ERRORS FOUND");
		else
		begin
			foreach (rows[k])
			begin
				frame_errs = 0;
				for (int i = 0; i < rows[k].plen && rows[k].exp_stream != 2; i++)
					if (rows[k].exp_stream == 0 && got_data_0.size() > 0)
						check_byte(got_data_0.pop_front(), exp_data_0.pop_front(), "data 0");
					else if (rows[k].exp_stream == 1 && got_data_1.size() > 0)
						check_byte(got_data_1.pop_front(), exp_data_1.pop_front(), "data 1");
					else
					begin
						$display("frame %0d is missing payload bytes", k);
						errors++;
						frame_errs++;
					end
				if (rows[k].exp_stream == 0 && got_stat_0.size() > 0)
					check_status(got_stat_0.pop_front(), exp_stat_0.pop_front(), "status 0");
				else if (rows[k].exp_stream == 1 && got_stat_1.size() > 0)
					check_status(got_stat_1.pop_front(), exp_stat_1.pop_front(), "status 1");
				else if (rows[k].exp_stream != 2)
				begin
					$display("frame %0d has no status record", k);
					errors++;
					frame_errs++;
				end
				if (frame_errs == 0)
					passed++;
				$display("frame %0d stream %0d: %s", k, rows[k].exp_stream,
					(frame_errs == 0) ? "ok" : "failed");
			end
			if (got_data_0.size() + got_data_1.size() + got_stat_0.size() + got_stat_1.size() != 0)
			begin
				$display("FIFOs held entries that no frame should have produced");
				errors++;
			end
			if (assertion_failures() != 0)
			begin
				$display("%0d concurrent assertions failed during the run", assertion_failures());
				errors++;
			end
			$display("%0d frames passed, %0d failed, %0d errors", passed, rows.size() - passed,
				errors);
			if (errors == 0)
				$display("NO ERRORS");
			else
				$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
